//--- source/cacheBusPkg.sv
package cacheBusPkg;

  // core side
  typedef struct packed {
    logic               valid;
    logic               write;
    cacheGeomPkg::addrT addr;
    cacheGeomPkg::wordT wdata;
    cacheGeomPkg::maskT mask;
  } coreReqT;

  typedef struct packed {
    logic               valid;
    logic               write;
    cacheGeomPkg::wordT rdata;
  } coreRespT;

  // memory side with line aligned addresses
  typedef struct packed {
    logic               valid;
    logic               write;
    cacheGeomPkg::addrT addr;
    cacheGeomPkg::lineT data;
  } memReqT;

  typedef struct packed {
    logic               valid;
    cacheGeomPkg::wordT data;
    logic               last;
  } memBeatT;

  // hit stage to refill engine
  typedef struct packed {
    logic               valid;
    logic               write;
    cacheGeomPkg::addrT addr;
    cacheGeomPkg::wordT wdata;
    cacheGeomPkg::maskT mask;
    logic               victimWay;
    logic               victimDirty;
    cacheGeomPkg::tagT  victimTag;
    cacheGeomPkg::lineT victimLine;
  } missReqT;

  // refill engine back to the arrays and the hit stage
  typedef struct packed {
    logic                valid;
    logic                way;
    cacheGeomPkg::indexT index;
    cacheGeomPkg::tagT   tag;
    cacheGeomPkg::lineT  line;
    logic                dirty;
  } fillT;

endpackage

//--- source/cacheGeomPkg.sv
package cacheGeomPkg;

  localparam int addrWidth   = 32;
  localparam int wordWidth   = 64;
  localparam int lineWords   = 4;
  localparam int lineWidth   = wordWidth * lineWords;
  localparam int maskWidth   = wordWidth / 8;
  localparam int offsetBits  = 5;
  localparam int indexBits   = 6;
  localparam int tagBits     = addrWidth - indexBits - offsetBits;
  localparam int wordSelBits = 2;
  localparam int numWays     = 2;

  typedef logic [addrWidth-1:0]   addrT;
  typedef logic [wordWidth-1:0]   wordT;
  typedef logic [lineWidth-1:0]   lineT;
  typedef logic [maskWidth-1:0]   maskT;
  typedef logic [tagBits-1:0]     tagT;
  typedef logic [indexBits-1:0]   indexT;
  typedef logic [wordSelBits-1:0] wordSelT;

  // address splits into tag, index, word select and byte offset
  function automatic indexT addrIndex(addrT addr);
    return addr[offsetBits +: indexBits];
  endfunction

  function automatic tagT addrTag(addrT addr);
    return addr[offsetBits+indexBits +: tagBits];
  endfunction

  function automatic wordSelT addrSel(addrT addr);
    return addr[offsetBits-wordSelBits +: wordSelBits];
  endfunction

  function automatic addrT lineAddr(tagT tag, indexT index);
    return {tag, index, {offsetBits{1'b0}}};
  endfunction

endpackage

//--- source/dataArray.sv
module dataArray #(
  parameter int numSets = 64
) (
  input  logic                                             clk,
  input  cacheGeomPkg::indexT                              rdIndex_i,
  input  logic                                             rdEn_i,
  input  logic                                             wrEn_i,
  input  logic                                             wrWay_i,
  input  cacheGeomPkg::indexT                              wrIndex_i,
  input  cacheGeomPkg::wordSelT                            wrSel_i,
  input  cacheGeomPkg::wordT                               wrData_i,
  input  cacheGeomPkg::maskT                               wrMask_i,
  input  cacheBusPkg::fillT                                fill_i,
  output cacheGeomPkg::lineT [cacheGeomPkg::numWays-1:0] lines_o
);

  localparam int setBits = $clog2(numSets);

  cacheGeomPkg::lineT lineMem [cacheGeomPkg::numWays][numSets];
  logic [setBits-1:0] rdSet;
  logic [setBits-1:0] wrSet;

  assign rdSet = rdIndex_i[setBits-1:0];
  assign wrSet = wrIndex_i[setBits-1:0];

  // fill replaces the whole line, a store only its enabled bytes
  always_ff @(posedge clk) begin
    if (fill_i.valid) begin
      lineMem[fill_i.way][fill_i.index[setBits-1:0]] <= fill_i.line;
    end else if (wrEn_i) begin
      for (int b = 0; b < cacheGeomPkg::maskWidth; b++) begin
        if (wrMask_i[b]) begin
          lineMem[wrWay_i][wrSet][wrSel_i*cacheGeomPkg::wordWidth + b*8 +: 8] <=
            wrData_i[b*8 +: 8];
        end
      end
    end
  end

  // both ways come back one cycle later
  always_ff @(posedge clk) begin
    if (rdEn_i) begin
      for (int w = 0; w < cacheGeomPkg::numWays; w++) begin
        lines_o[w] <= lineMem[w][rdSet];
      end
    end
  end

endmodule

//--- source/dcacheTop.sv
module dcacheTop #(
  parameter int reqDepth = 4,
  parameter int numSets  = 64
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cacheBusPkg::coreReqT  cpuReq_i,
  output logic                  creditReturn_o,
  output cacheBusPkg::coreRespT cpuResp_o,
  output cacheBusPkg::memReqT   memReq_o,
  input  logic                  memReady_i,
  input  cacheBusPkg::memBeatT  memBeat_i
);

  cacheBusPkg::coreReqT                             head;
  logic                                             pop;
  cacheGeomPkg::indexT                              lookIndex;
  cacheGeomPkg::tagT [cacheGeomPkg::numWays-1:0]  tags;
  logic [cacheGeomPkg::numWays-1:0]               valid;
  logic [cacheGeomPkg::numWays-1:0]               dirty;
  logic                                             victimWay;
  cacheGeomPkg::lineT [cacheGeomPkg::numWays-1:0] lines;
  cacheBusPkg::fillT                                fill;
  cacheBusPkg::missReqT                             miss;
  logic                                             storeWr;
  logic                                             storeWay;
  cacheGeomPkg::indexT                              storeIndex;
  cacheGeomPkg::wordSelT                            storeSel;
  cacheGeomPkg::wordT                               storeData;
  cacheGeomPkg::maskT                               storeMask;

  // lookup reads the arrays with the head's set in the pop cycle
  assign lookIndex = cacheGeomPkg::addrIndex(head.addr);

  reqQueue #(.reqDepth(reqDepth)) queue0 (
    .clk(clk), .rst_n(rst_n), .enq_i(cpuReq_i), .pop_i(pop),
    .head_o(head), .creditReturn_o(creditReturn_o)
  );

  tagStore #(.numSets(numSets)) tags0 (
    .clk(clk), .rst_n(rst_n), .rdIndex_i(lookIndex), .rdEn_i(pop),
    .setWrite_i(storeWr), .setWriteWay_i(storeWay), .fill_i(fill),
    .tags_o(tags), .valid_o(valid), .dirty_o(dirty), .victimWay_o(victimWay)
  );

  dataArray #(.numSets(numSets)) data0 (
    .clk(clk), .rdIndex_i(lookIndex), .rdEn_i(pop), .wrEn_i(storeWr),
    .wrWay_i(storeWay), .wrIndex_i(storeIndex), .wrSel_i(storeSel),
    .wrData_i(storeData), .wrMask_i(storeMask), .fill_i(fill), .lines_o(lines)
  );

  hitStage hit0 (
    .clk(clk), .rst_n(rst_n), .head_i(head), .pop_o(pop), .tags_i(tags),
    .valid_i(valid), .dirty_i(dirty), .victimWay_i(victimWay), .lines_i(lines),
    .fill_i(fill), .miss_o(miss), .storeWr_o(storeWr), .storeWay_o(storeWay),
    .storeIndex_o(storeIndex), .storeSel_o(storeSel), .storeData_o(storeData),
    .storeMask_o(storeMask), .resp_o(cpuResp_o)
  );

  refillEngine refill0 (
    .clk(clk), .rst_n(rst_n), .miss_i(miss), .memReq_o(memReq_o),
    .memReady_i(memReady_i), .memBeat_i(memBeat_i), .fill_o(fill)
  );

endmodule

//--- source/hitStage.sv
module hitStage (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  cacheBusPkg::coreReqT                             head_i,
  output logic                                             pop_o,
  input  cacheGeomPkg::tagT [cacheGeomPkg::numWays-1:0]  tags_i,
  input  logic [cacheGeomPkg::numWays-1:0]               valid_i,
  input  logic [cacheGeomPkg::numWays-1:0]               dirty_i,
  input  logic                                             victimWay_i,
  input  cacheGeomPkg::lineT [cacheGeomPkg::numWays-1:0] lines_i,
  input  cacheBusPkg::fillT                                fill_i,
  output cacheBusPkg::missReqT                             miss_o,
  output logic                                             storeWr_o,
  output logic                                             storeWay_o,
  output cacheGeomPkg::indexT                              storeIndex_o,
  output cacheGeomPkg::wordSelT                            storeSel_o,
  output cacheGeomPkg::wordT                               storeData_o,
  output cacheGeomPkg::maskT                               storeMask_o,
  output cacheBusPkg::coreRespT                            resp_o
);

  localparam int wordWidth = cacheGeomPkg::wordWidth;

  cacheBusPkg::coreReqT                 cur;
  logic                                 regValid;
  logic                                 waiting;
  cacheGeomPkg::indexT                  curIndex;
  cacheGeomPkg::tagT                    curTag;
  cacheGeomPkg::wordSelT                curSel;
  logic [cacheGeomPkg::numWays-1:0]     wayHit;
  logic                                 compare;
  logic                                 isHit;
  logic                                 isMiss;
  logic                                 fillDone;
  logic                                 setClash;
  cacheGeomPkg::lineT                   hitLine;

  assign curIndex = cacheGeomPkg::addrIndex(cur.addr);
  assign curTag   = cacheGeomPkg::addrTag(cur.addr);
  assign curSel   = cacheGeomPkg::addrSel(cur.addr);

  always_comb begin
    for (int w = 0; w < cacheGeomPkg::numWays; w++) begin
      wayHit[w] = valid_i[w] && (tags_i[w] == curTag);
    end
  end

  // compare only in the cycle after the lookup, never while a miss is out
  assign compare  = regValid && !waiting;
  assign isHit    = compare && (|wayHit);
  assign isMiss   = compare && !(|wayHit);
  assign fillDone = waiting && fill_i.valid;
  assign hitLine  = lines_i[wayHit[1]];

  assign storeWr_o    = isHit && cur.write;
  assign storeWay_o   = wayHit[1];
  assign storeIndex_o = curIndex;
  assign storeSel_o   = curSel;
  assign storeData_o  = cur.wdata;
  assign storeMask_o  = cur.mask;

  // a lookup of the set being stored to would read the old line
  assign setClash = storeWr_o && (cacheGeomPkg::addrIndex(head_i.addr) == curIndex);
  assign pop_o    = head_i.valid && (!regValid || (isHit && !setClash));

  always_comb begin
    miss_o.valid       = isMiss;
    miss_o.write       = cur.write;
    miss_o.addr        = cur.addr;
    miss_o.wdata       = cur.wdata;
    miss_o.mask        = cur.mask;
    miss_o.victimWay   = victimWay_i;
    miss_o.victimDirty = valid_i[victimWay_i] && dirty_i[victimWay_i];
    miss_o.victimTag   = tags_i[victimWay_i];
    miss_o.victimLine  = lines_i[victimWay_i];
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      cur <= head_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regValid <= 1'b0;
      waiting  <= 1'b0;
      resp_o   <= '0;
    end else begin
      if (pop_o) begin
        regValid <= 1'b1;
      end else if (isHit || fillDone) begin
        regValid <= 1'b0;
      end
      if (isMiss) begin
        waiting <= 1'b1;
      end else if (fillDone) begin
        waiting <= 1'b0;
      end
      resp_o.valid <= isHit || fillDone;
      resp_o.write <= cur.write;
      // stores are acknowledged with zero data
      if (cur.write) begin
        resp_o.rdata <= '0;
      end else if (fillDone) begin
        resp_o.rdata <= fill_i.line[curSel*wordWidth +: wordWidth];
      end else begin
        resp_o.rdata <= hitLine[curSel*wordWidth +: wordWidth];
      end
    end
  end

endmodule

//--- source/refillEngine.sv
module refillEngine (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cacheBusPkg::missReqT miss_i,
  output cacheBusPkg::memReqT  memReq_o,
  input  logic                 memReady_i,
  input  cacheBusPkg::memBeatT memBeat_i,
  output cacheBusPkg::fillT    fill_o
);

  localparam int wordWidth = cacheGeomPkg::wordWidth;

  typedef enum logic [2:0] {
    idle,
    writeBack,
    readReq,
    collect,
    install
  } stateT;

  stateT                 state;
  cacheBusPkg::missReqT  req;
  cacheGeomPkg::lineT    lineBuf;
  cacheGeomPkg::lineT    merged;
  cacheGeomPkg::wordSelT beatCnt;
  cacheGeomPkg::wordSelT reqSel;
  cacheGeomPkg::indexT   reqIndex;

  assign reqSel   = cacheGeomPkg::addrSel(req.addr);
  assign reqIndex = cacheGeomPkg::addrIndex(req.addr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= idle;
      beatCnt <= '0;
    end else begin
      case (state)
        idle: begin
          if (miss_i.valid) begin
            state <= miss_i.victimDirty ? writeBack : readReq;
          end
        end
        writeBack: begin
          if (memReady_i) begin
            state <= readReq;
          end
        end
        readReq: begin
          if (memReady_i) begin
            state   <= collect;
            beatCnt <= '0;
          end
        end
        collect: begin
          if (memBeat_i.valid) begin
            beatCnt <= beatCnt + 1'b1;
            if (memBeat_i.last) begin
              state <= install;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // buffer starts as the victim line, then beats overwrite it word by word
  always_ff @(posedge clk) begin
    if (state == idle && miss_i.valid) begin
      req     <= miss_i;
      lineBuf <= miss_i.victimLine;
    end else if (state == collect && memBeat_i.valid) begin
      lineBuf[beatCnt*wordWidth +: wordWidth] <= memBeat_i.data;
    end
  end

  // pending store lands in the refilled line
  always_comb begin
    merged = lineBuf;
    if (req.write) begin
      for (int b = 0; b < cacheGeomPkg::maskWidth; b++) begin
        if (req.mask[b]) begin
          merged[reqSel*wordWidth + b*8 +: 8] = req.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_comb begin
    memReq_o.valid = (state == writeBack) || (state == readReq);
    memReq_o.write = (state == writeBack);
    if (state == writeBack) begin
      memReq_o.addr = cacheGeomPkg::lineAddr(req.victimTag, reqIndex);
    end else begin
      memReq_o.addr = cacheGeomPkg::lineAddr(cacheGeomPkg::addrTag(req.addr), reqIndex);
    end
    memReq_o.data = lineBuf;
  end

  always_comb begin
    fill_o.valid = (state == install);
    fill_o.way   = req.victimWay;
    fill_o.index = reqIndex;
    fill_o.tag   = cacheGeomPkg::addrTag(req.addr);
    fill_o.line  = merged;
    fill_o.dirty = req.write;
  end

endmodule

//--- source/reqQueue.sv
module reqQueue #(
  parameter int reqDepth = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cacheBusPkg::coreReqT enq_i,
  input  logic                 pop_i,
  output cacheBusPkg::coreReqT head_o,
  output logic                 creditReturn_o
);

  localparam int ptrBits = (reqDepth > 1) ? $clog2(reqDepth) : 1;

  cacheBusPkg::coreReqT entries [reqDepth];
  logic [ptrBits-1:0]   wrPtr;
  logic [ptrBits-1:0]   rdPtr;
  logic [ptrBits:0]     count;

  always_ff @(posedge clk) begin
    if (enq_i.valid) begin
      entries[wrPtr] <= enq_i;
    end
  end

  // the requester spends one credit per push
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wrPtr          <= '0;
      rdPtr          <= '0;
      count          <= '0;
      creditReturn_o <= 1'b0;
    end else begin
      if (enq_i.valid) begin
        wrPtr <= (wrPtr == ptrBits'(reqDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop_i) begin
        rdPtr <= (rdPtr == ptrBits'(reqDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      count          <= count + (ptrBits+1)'(enq_i.valid) - (ptrBits+1)'(pop_i);
      creditReturn_o <= pop_i;
    end
  end

  always_comb begin
    head_o       = entries[rdPtr];
    head_o.valid = (count != '0);
  end

endmodule

//--- source/tagStore.sv
module tagStore #(
  parameter int numSets = 64
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  cacheGeomPkg::indexT                             rdIndex_i,
  input  logic                                            rdEn_i,
  input  logic                                            setWrite_i,
  input  logic                                            setWriteWay_i,
  input  cacheBusPkg::fillT                               fill_i,
  output cacheGeomPkg::tagT [cacheGeomPkg::numWays-1:0] tags_o,
  output logic [cacheGeomPkg::numWays-1:0]              valid_o,
  output logic [cacheGeomPkg::numWays-1:0]              dirty_o,
  output logic                                            victimWay_o
);

  localparam int setBits = $clog2(numSets);

  cacheGeomPkg::tagT tagMem [cacheGeomPkg::numWays][numSets];
  logic [numSets-1:0][cacheGeomPkg::numWays-1:0] validBits;
  logic [numSets-1:0][cacheGeomPkg::numWays-1:0] dirtyBits;
  logic [numSets-1:0]                            rrBits;
  logic [setBits-1:0] rdSet;
  logic [setBits-1:0] fillSet;
  logic [setBits-1:0] lookSet;
  logic               rdVictim;

  assign rdSet   = rdIndex_i[setBits-1:0];
  assign fillSet = fill_i.index[setBits-1:0];

  // invalid way first, then round robin
  always_comb begin
    if (!validBits[rdSet][0]) begin
      rdVictim = 1'b0;
    end else if (!validBits[rdSet][1]) begin
      rdVictim = 1'b1;
    end else begin
      rdVictim = rrBits[rdSet];
    end
  end

  always_ff @(posedge clk) begin
    if (fill_i.valid) begin
      tagMem[fill_i.way][fillSet] <= fill_i.tag;
    end
    if (rdEn_i) begin
      lookSet   <= rdSet;
      tags_o[0] <= tagMem[0][rdSet];
      tags_o[1] <= tagMem[1][rdSet];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits   <= '0;
      dirtyBits   <= '0;
      rrBits      <= '0;
      valid_o     <= '0;
      dirty_o     <= '0;
      victimWay_o <= 1'b0;
    end else begin
      if (fill_i.valid) begin
        validBits[fillSet][fill_i.way] <= 1'b1;
        dirtyBits[fillSet][fill_i.way] <= fill_i.dirty;
        if (&validBits[fillSet]) begin
          rrBits[fillSet] <= ~rrBits[fillSet];
        end
      end
      // store hit targets the set of the last lookup
      if (setWrite_i) begin
        dirtyBits[lookSet][setWriteWay_i] <= 1'b1;
      end
      if (rdEn_i) begin
        valid_o     <= validBits[rdSet];
        dirty_o     <= dirtyBits[rdSet];
        victimWay_o <= rdVictim;
      end
    end
  end

endmodule

//--- tests/dcacheTb.sv
module dcacheTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int reqDepth     = 4;
  localparam int numSets      = 64;
  localparam int directedReqs = 11;
  localparam int randReqs     = 200;
  localparam int cycleLimit   = 40 * (directedReqs + randReqs) + 2000;

  logic                  clk;
  logic                  rst_n;
  cacheBusPkg::coreReqT  cpuReq;
  logic                  creditReturn;
  cacheBusPkg::coreRespT cpuResp;
  cacheBusPkg::memReqT   memReq;
  logic                  memReady;
  cacheBusPkg::memBeatT  memBeat;

  // shadow memory by word address and a copy of the tag state
  cacheGeomPkg::wordT    shadow [cacheGeomPkg::addrT];
  cacheGeomPkg::tagT     modelTag [numSets][2];
  logic                  modelValid [numSets][2];
  logic                  modelDirty [numSets][2];
  logic                  modelRr [numSets];
  cacheBusPkg::coreRespT expQ [$];
  cacheBusPkg::memReqT   reqLog [$];
  integer                seed;
  int                    sent;
  int                    returned = 0;
  int                    cycles = 0;

  tbClock #(.periodNs(40), .resetCycles(2)) clkGen0 (.clk_o(clk), .rst_n_o(rst_n));

  dcacheTop #(.reqDepth(reqDepth), .numSets(numSets)) dut0 (
    .clk(clk), .rst_n(rst_n), .cpuReq_i(cpuReq), .creditReturn_o(creditReturn),
    .cpuResp_o(cpuResp), .memReq_o(memReq), .memReady_i(memReady), .memBeat_i(memBeat)
  );

  memModel mem0 (
    .clk(clk), .rst_n(rst_n), .memReq_i(memReq), .memReady_o(memReady), .memBeat_o(memBeat)
  );

  task automatic checkValue(input string name, input logic [255:0] got,
                            input logic [255:0] expected);
    if (got !== expected) begin
      $display("error %s: got %0h expected %0h", name, got, expected);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  function automatic cacheGeomPkg::wordT shadowRead(cacheGeomPkg::addrT wordAddr);
    if (shadow.exists(wordAddr)) begin
      return shadow[wordAddr];
    end
    return {wordAddr, ~wordAddr};
  endfunction

  function automatic cacheGeomPkg::wordT expandMask(cacheGeomPkg::maskT mask);
    cacheGeomPkg::wordT bits;
    for (int b = 0; b < 8; b++) begin
      bits[b*8 +: 8] = {8{mask[b]}};
    end
    return bits;
  endfunction

  // invalid way 0, then invalid way 1, then the round robin bit
  function automatic logic predictVictim(int set);
    if (!modelValid[set][0]) begin
      return 1'b0;
    end else if (!modelValid[set][1]) begin
      return 1'b1;
    end
    return modelRr[set];
  endfunction

  function automatic void trackAccess(input logic write, input cacheGeomPkg::addrT addr);
    int                set;
    cacheGeomPkg::tagT tag;
    logic              way;
    logic              hit;
    set = addr[10:5];
    tag = addr[31:11];
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (modelValid[set][w] && modelTag[set][w] == tag) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (!hit) begin
      way = predictVictim(set);
      if (modelValid[set][0] && modelValid[set][1]) begin
        modelRr[set] = ~modelRr[set];
      end
      modelTag[set][way]   = tag;
      modelValid[set][way] = 1'b1;
      modelDirty[set][way] = 1'b0;
    end
    if (write) begin
      modelDirty[set][way] = 1'b1;
    end
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #2;
  endtask

  // one request per call, only while a credit is held
  task automatic sendReq(input logic write, input cacheGeomPkg::addrT addr,
                         input cacheGeomPkg::wordT wdata, input cacheGeomPkg::maskT mask);
    cacheBusPkg::coreRespT exp;
    cacheGeomPkg::addrT    wordAddr;
    cacheGeomPkg::wordT    byteMask;
    wordAddr = addr >> 3;
    while (sent - returned >= reqDepth) begin
      nextCycle();
    end
    exp.valid = 1'b1;
    exp.write = write;
    if (write) begin
      byteMask         = expandMask(mask);
      shadow[wordAddr] = (shadowRead(wordAddr) & ~byteMask) | (wdata & byteMask);
      exp.rdata        = '0;
    end else begin
      exp.rdata = shadowRead(wordAddr);
    end
    trackAccess(write, addr);
    expQ.push_back(exp);
    cpuReq.valid = 1'b1;
    cpuReq.write = write;
    cpuReq.addr  = addr;
    cpuReq.wdata = wdata;
    cpuReq.mask  = mask;
    sent         = sent + 1;
    nextCycle();
    cpuReq.valid = 1'b0;
  endtask

  task automatic waitIdle();
    while (expQ.size() != 0) begin
      nextCycle();
    end
  endtask

  task automatic checkResponse();
    cacheBusPkg::coreRespT exp;
    if (expQ.size() == 0) begin
      failRun("response arrived with no request outstanding");
    end
    exp = expQ.pop_front();
    checkValue("cpuResp_o.write", cpuResp.write, exp.write);
    checkValue("cpuResp_o.rdata", cpuResp.rdata, exp.rdata);
  endtask

  // outputs sampled mid cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (creditReturn) begin
        returned = returned + 1;
        if (returned > sent) begin
          failRun("credit returned with no request outstanding");
        end
      end
      if (memReq.valid && memReady) begin
        reqLog.push_back(memReq);
      end
      if (cpuResp.valid) begin
        checkResponse();
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  task automatic coldLoadMiss();
    reqLog.delete();
    sendReq(1'b0, 32'h0000_1048, '0, '0);
    waitIdle();
    checkValue("memReq_o count", reqLog.size(), 1);
    checkValue("memReq_o.write", reqLog[0].write, 1'b0);
    checkValue("memReq_o.addr", reqLog[0].addr, 32'h0000_1040);
  endtask

  task automatic loadHit();
    reqLog.delete();
    sendReq(1'b0, 32'h0000_1058, '0, '0);
    waitIdle();
    checkValue("memReq_o count", reqLog.size(), 0);
  endtask

  task automatic storeThenLoad();
    reqLog.delete();
    sendReq(1'b1, 32'h0000_1050, 64'h1122_3344_5566_7788, 8'h0F);
    sendReq(1'b0, 32'h0000_1050, '0, '0);
    waitIdle();
    checkValue("memReq_o count", reqLog.size(), 0);
  endtask

  task automatic dirtyEviction();
    logic               victim;
    cacheGeomPkg::addrT victimAddr;
    cacheGeomPkg::lineT victimData;
    // second line of set 2 takes the free way
    sendReq(1'b0, 32'h0000_1840, '0, '0);
    waitIdle();
    victim     = predictVictim(2);
    victimAddr = {modelTag[2][victim], 6'd2, 5'd0};
    if (!modelDirty[2][victim]) begin
      failRun("predicted victim of set 2 is not dirty");
    end
    for (int i = 0; i < 4; i++) begin
      victimData[i*64 +: 64] = shadowRead((victimAddr >> 3) + i);
    end
    reqLog.delete();
    sendReq(1'b0, 32'h0000_2048, '0, '0);
    waitIdle();
    checkValue("memReq_o count", reqLog.size(), 2);
    checkValue("memReq_o.write", reqLog[0].write, 1'b1);
    checkValue("memReq_o.addr", reqLog[0].addr, victimAddr);
    checkValue("memReq_o.data", reqLog[0].data, victimData);
    checkValue("memReq_o.write", reqLog[1].write, 1'b0);
    checkValue("memReq_o.addr", reqLog[1].addr, 32'h0000_2040);
    // evicted line comes back with the stored bytes
    sendReq(1'b0, 32'h0000_1050, '0, '0);
    waitIdle();
  endtask

  task automatic creditRun();
    cacheGeomPkg::addrT addr;
    logic               write;
    // all credits held here, spend them back to back
    for (int i = 0; i < reqDepth; i++) begin
      sendReq(1'b0, 32'h0000_0100 + 32'(i * 8), '0, '0);
    end
    for (int n = 0; n < randReqs; n++) begin
      addr        = '0;
      addr[13:11] = 3'($random(seed));
      addr[6:5]   = 2'($random(seed));
      addr[4:3]   = 2'($random(seed));
      write       = (2'($random(seed)) == 2'd0);
      sendReq(write, addr, {$random(seed), $random(seed)}, 8'($random(seed)));
    end
    waitIdle();
    nextCycle();
    checkValue("credits returned", returned, sent);
  endtask

  initial begin
    seed   = 32'h4207;
    sent   = 0;
    cpuReq = '0;
    for (int s = 0; s < numSets; s++) begin
      modelRr[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        modelTag[s][w]   = '0;
        modelValid[s][w] = 1'b0;
        modelDirty[s][w] = 1'b0;
      end
    end
    wait (rst_n);
    nextCycle();
    coldLoadMiss();
    loadHit();
    storeThenLoad();
    dirtyEviction();
    creditRun();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- tests/memModel.sv
module memModel (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cacheBusPkg::memReqT  memReq_i,
  output logic                 memReady_o,
  output cacheBusPkg::memBeatT memBeat_o
);

  timeunit 1ns;
  timeprecision 100ps;

  cacheGeomPkg::wordT  stored [cacheGeomPkg::addrT];
  integer              seed;
  cacheGeomPkg::addrT  beatAddr;
  int                  beatsLeft;
  logic                accepted;
  cacheBusPkg::memReqT taken;

  // word address a holds {a, ~a} until written back
  function automatic cacheGeomPkg::wordT readWord(cacheGeomPkg::addrT wordAddr);
    if (stored.exists(wordAddr)) begin
      return stored[wordAddr];
    end
    return {wordAddr, ~wordAddr};
  endfunction

  initial begin
    cacheGeomPkg::addrT wordAddr;
    seed       = 32'h4207;
    memReady_o = 1'b0;
    memBeat_o  = '0;
    beatsLeft  = 0;
    accepted   = 1'b0;
    wait (rst_n);
    forever begin
      // request is stable mid cycle, handshake completes at the next edge
      @(negedge clk);
      accepted = memReq_i.valid && memReady_o;
      taken    = memReq_i;
      @(posedge clk);
      #2;
      if (accepted && taken.write) begin
        for (int i = 0; i < 4; i++) begin
          wordAddr         = (taken.addr >> 3) + i;
          stored[wordAddr] = taken.data[i*64 +: 64];
        end
      end else if (accepted) begin
        beatAddr  = taken.addr >> 3;
        beatsLeft = 4;
      end
      // beats with random gaps
      memBeat_o = '0;
      if (beatsLeft > 0 && 2'($random(seed)) != 2'd0) begin
        memBeat_o.valid = 1'b1;
        memBeat_o.data  = readWord(beatAddr);
        memBeat_o.last  = (beatsLeft == 1);
        beatAddr        = beatAddr + 1;
        beatsLeft       = beatsLeft - 1;
      end
      memReady_o = (2'($random(seed)) != 2'd0);
    end
  end

endmodule

//--- tests/tbClock.sv
module tbClock #(
  parameter int periodNs    = 40,
  parameter int resetCycles = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(periodNs / 2) clk_o = ~clk_o;
    end
  end

  // release just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (resetCycles) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

//--- vlog.f
source/cacheGeomPkg.sv
source/cacheBusPkg.sv
source/reqQueue.sv
source/tagStore.sv
source/dataArray.sv
source/hitStage.sv
source/refillEngine.sv
source/dcacheTop.sv
tests/tbClock.sv
tests/memModel.sv
tests/dcacheTb.sv
